//--- alu_unit.sv
`default_nettype none

module alu_unit
    import isa_pkg::*;
(
    input  oper_t oper,
    input  word_t src_a,
    input  word_t src_b,
    input  word_t offset,
    output word_t result,
    output word_t mem_addr
);

    always_comb begin
        case (oper)
            OP_ADD:  result = src_a + src_b;
            OP_SUB:  result = src_a - src_b;
            OP_AND:  result = src_a & src_b;
            OP_OR:   result = src_a | src_b;
            OP_XOR:  result = src_a ^ src_b;
            // signed compare
            OP_SLT:  result = ($signed(src_a) < $signed(src_b)) ? word_t'(1) : ZERO_WORD;
            default: result = ZERO_WORD;
        endcase
    end

    // byte address for loads and stores
    always_comb begin
        if (oper == OP_LW || oper == OP_SW) begin
            mem_addr = src_a + offset;
        end else begin
            mem_addr = ZERO_WORD;
        end
    end

endmodule

`default_nettype wire

//--- ex_mem.sv
`default_nettype none

module ex_mem
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  stall_t    stall,

    input  logic      ex_wreg_write,
    input  reg_addr_t ex_wreg_addr,
    input  word_t     ex_wreg_data,
    output logic      mem_wreg_write,
    output reg_addr_t mem_wreg_addr,
    output word_t     mem_wreg_data,

    // hilo
    input  logic      ex_whilo,
    input  word_t     ex_hi,
    input  word_t     ex_lo,
    output logic      mem_whilo,
    output word_t     mem_hi,
    output word_t     mem_lo,

    // memory access
    input  oper_t     ex_oper,
    input  word_t     ex_mem_oper_addr,
    input  word_t     ex_mem_oper_data,
    output oper_t     mem_oper,
    output word_t     mem_mem_oper_addr,
    output word_t     mem_mem_oper_data,

    // cp0 write
    input  logic      ex_cp0_reg_we,
    input  reg_addr_t ex_cp0_reg_write_addr,
    input  word_t     ex_cp0_reg_data,
    output logic      mem_cp0_reg_we,
    output reg_addr_t mem_cp0_reg_write_addr,
    output word_t     mem_cp0_reg_data
);

    logic load;
    logic bubble;

    // advance, or insert a bubble behind a stalled execute stage
    assign load   = !stall[ST_EX] || !stall[ST_MEM];
    assign bubble = stall[ST_EX];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_wreg_write         <= 1'b0;
            mem_wreg_addr          <= REG_ZERO;
            mem_wreg_data          <= ZERO_WORD;
            mem_whilo              <= 1'b0;
            mem_hi                 <= ZERO_WORD;
            mem_lo                 <= ZERO_WORD;
            mem_oper               <= OP_NOP;
            mem_mem_oper_addr      <= ZERO_WORD;
            mem_mem_oper_data      <= ZERO_WORD;
            mem_cp0_reg_we         <= 1'b0;
            mem_cp0_reg_write_addr <= REG_ZERO;
            mem_cp0_reg_data       <= ZERO_WORD;
        end else if (load) begin
            mem_wreg_write         <= bubble ? 1'b0 : ex_wreg_write;
            mem_wreg_addr          <= bubble ? REG_ZERO : ex_wreg_addr;
            mem_wreg_data          <= bubble ? ZERO_WORD : ex_wreg_data;
            mem_whilo              <= bubble ? 1'b0 : ex_whilo;
            mem_hi                 <= bubble ? ZERO_WORD : ex_hi;
            mem_lo                 <= bubble ? ZERO_WORD : ex_lo;
            mem_oper               <= bubble ? OP_NOP : ex_oper;
            mem_mem_oper_addr      <= bubble ? ZERO_WORD : ex_mem_oper_addr;
            mem_mem_oper_data      <= bubble ? ZERO_WORD : ex_mem_oper_data;
            mem_cp0_reg_we         <= bubble ? 1'b0 : ex_cp0_reg_we;
            mem_cp0_reg_write_addr <= bubble ? REG_ZERO : ex_cp0_reg_write_addr;
            mem_cp0_reg_data       <= bubble ? ZERO_WORD : ex_cp0_reg_data;
        end
    end

endmodule

`default_nettype wire

//--- ex_stage.sv
`default_nettype none

module ex_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    input  logic      in_ready,
    input  oper_t     in_oper,
    input  word_t     in_src_a,
    input  word_t     in_src_b,
    input  word_t     in_offset,
    input  reg_addr_t in_dest,
    input  stall_t    stall,
    output logic      mult_busy,

    output logic      ex_wreg_write,
    output reg_addr_t ex_wreg_addr,
    output word_t     ex_wreg_data,

    output logic      ex_whilo,
    output word_t     ex_hi,
    output word_t     ex_lo,

    output oper_t     ex_oper,
    output word_t     ex_mem_oper_addr,
    output word_t     ex_mem_oper_data,

    output logic      ex_cp0_reg_we,
    output reg_addr_t ex_cp0_reg_write_addr,
    output word_t     ex_cp0_reg_data
);

    logic  accept;
    logic  mult_done;
    word_t alu_result;
    word_t alu_addr;
    word_t mult_hi;
    word_t mult_lo;

    assign accept = in_valid && in_ready;

    alu_unit i_alu_unit (
        .oper     (in_oper),
        .src_a    (in_src_a),
        .src_b    (in_src_b),
        .offset   (in_offset),
        .result   (alu_result),
        .mem_addr (alu_addr)
    );

    // count freezes only under writeback back-pressure
    mult_unit i_mult_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (accept && in_oper == OP_MULTU),
        .hold         (stall[ST_EX] && stall[ST_MEM]),
        .multiplicand (in_src_a),
        .multiplier   (in_src_b),
        .busy         (mult_busy),
        .done         (mult_done),
        .hi           (mult_hi),
        .lo           (mult_lo)
    );

    always_comb begin
        ex_wreg_write         = 1'b0;
        ex_wreg_addr          = REG_ZERO;
        ex_wreg_data          = ZERO_WORD;
        ex_whilo              = 1'b0;
        ex_hi                 = ZERO_WORD;
        ex_lo                 = ZERO_WORD;
        ex_oper               = OP_NOP;
        ex_mem_oper_addr      = ZERO_WORD;
        ex_mem_oper_data      = ZERO_WORD;
        ex_cp0_reg_we         = 1'b0;
        ex_cp0_reg_write_addr = REG_ZERO;
        ex_cp0_reg_data       = ZERO_WORD;

        // input is blocked while the multiplier runs, so these never collide
        if (mult_done) begin
            ex_oper  = OP_MULTU;
            ex_whilo = 1'b1;
            ex_hi    = mult_hi;
            ex_lo    = mult_lo;
        end else if (accept) begin
            case (in_oper)
                OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT: begin
                    ex_oper       = in_oper;
                    ex_wreg_write = 1'b1;
                    ex_wreg_addr  = in_dest;
                    ex_wreg_data  = alu_result;
                end
                // load data is filled in by the memory stage
                OP_LW: begin
                    ex_oper          = OP_LW;
                    ex_wreg_write    = 1'b1;
                    ex_wreg_addr     = in_dest;
                    ex_mem_oper_addr = alu_addr;
                end
                OP_SW: begin
                    ex_oper          = OP_SW;
                    ex_mem_oper_addr = alu_addr;
                    ex_mem_oper_data = in_src_b;
                end
                OP_MTC0: begin
                    ex_oper               = OP_MTC0;
                    ex_cp0_reg_we         = 1'b1;
                    ex_cp0_reg_write_addr = in_dest;
                    ex_cp0_reg_data       = in_src_b;
                end
                default: begin
                    ex_oper = OP_NOP;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- exec_mem_slice.sv
`default_nettype none

module exec_mem_slice
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    input  logic      in_valid,
    output logic      in_ready,
    input  oper_t     in_oper,
    input  word_t     in_src_a,
    input  word_t     in_src_b,
    input  word_t     in_offset,
    input  reg_addr_t in_dest,

    output logic      wb_valid,
    input  logic      wb_ready,
    output oper_t     wb_oper,
    output logic      wb_write,
    output reg_addr_t wb_addr,
    output word_t     wb_data,
    output logic      whilo,
    output word_t     hi,
    output word_t     lo,
    output logic      cp0_we,
    output reg_addr_t cp0_addr,
    output word_t     cp0_data
);

    stall_t    stall;
    logic      mult_busy;

    // execute to ex_mem
    logic      ex_wreg_write;
    reg_addr_t ex_wreg_addr;
    word_t     ex_wreg_data;
    logic      ex_whilo;
    word_t     ex_hi;
    word_t     ex_lo;
    oper_t     ex_oper;
    word_t     ex_mem_oper_addr;
    word_t     ex_mem_oper_data;
    logic      ex_cp0_reg_we;
    reg_addr_t ex_cp0_reg_write_addr;
    word_t     ex_cp0_reg_data;

    // ex_mem to memory stage
    logic      mem_wreg_write;
    reg_addr_t mem_wreg_addr;
    word_t     mem_wreg_data;
    logic      mem_whilo;
    word_t     mem_hi;
    word_t     mem_lo;
    oper_t     mem_oper;
    word_t     mem_mem_oper_addr;
    word_t     mem_mem_oper_data;
    logic      mem_cp0_reg_we;
    reg_addr_t mem_cp0_reg_write_addr;
    word_t     mem_cp0_reg_data;

    ex_stage i_ex_stage (.*);

    pipe_ctrl i_pipe_ctrl (.*);

    ex_mem i_ex_mem (.*);

    mem_stage i_mem_stage (.*);

endmodule

`default_nettype wire

//--- exec_mem_slice_assert.sv
`default_nettype none

module exec_mem_slice_assert
    import isa_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_ready,
    input  logic      mult_busy,
    input  logic      wb_valid,
    input  logic      wb_ready,
    input  oper_t     wb_oper,
    input  logic      wb_write,
    input  reg_addr_t wb_addr,
    input  word_t     wb_data,
    input  logic      whilo,
    input  word_t     hi,
    input  word_t     lo,
    input  logic      cp0_we,
    input  reg_addr_t cp0_addr,
    input  word_t     cp0_data
);

    timeunit 1ns;
    timeprecision 1ps;

    // a held result keeps its whole bundle
    a_wb_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        wb_valid && !wb_ready |=> wb_valid && $stable({wb_oper, wb_write, wb_addr, wb_data,
                                                       whilo, hi, lo, cp0_we, cp0_addr,
                                                       cp0_data})
    ) else $error("writeback bundle changed before it retired");

    a_busy_blocks_input: assert property (
        @(posedge clk) disable iff (!rst_n)
        mult_busy |-> !in_ready
    ) else $error("input ready while the multiplier is busy");

    a_reset_values: assert property (
        @(posedge clk)
        !rst_n |-> !wb_valid && in_ready
    ) else $error("wb_valid or in_ready wrong during reset");

endmodule

bind exec_mem_slice exec_mem_slice_assert i_exec_mem_slice_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_ready  (in_ready),
    .mult_busy (mult_busy),
    .wb_valid  (wb_valid),
    .wb_ready  (wb_ready),
    .wb_oper   (wb_oper),
    .wb_write  (wb_write),
    .wb_addr   (wb_addr),
    .wb_data   (wb_data),
    .whilo     (whilo),
    .hi        (hi),
    .lo        (lo),
    .cp0_we    (cp0_we),
    .cp0_addr  (cp0_addr),
    .cp0_data  (cp0_data)
);

`default_nettype wire

//--- isa_pkg.sv
`default_nettype none

package isa_pkg;

    localparam int WORD_W = 32;
    localparam int REG_AW = 5;

    typedef logic [WORD_W-1:0] word_t;

    // general-purpose and cp0 register numbers
    typedef logic [REG_AW-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_LW,
        OP_SW,
        OP_MULTU,
        OP_MTC0
    } oper_t;

    localparam word_t     ZERO_WORD = '0;
    localparam reg_addr_t REG_ZERO  = '0;

    // data RAM geometry, word addressed
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_AW    = 8;

endpackage

`default_nettype wire

//--- mem_stage.sv
`default_nettype none

module mem_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  stall_t    stall,

    input  logic      mem_wreg_write,
    input  reg_addr_t mem_wreg_addr,
    input  word_t     mem_wreg_data,
    input  logic      mem_whilo,
    input  word_t     mem_hi,
    input  word_t     mem_lo,
    input  oper_t     mem_oper,
    input  word_t     mem_mem_oper_addr,
    input  word_t     mem_mem_oper_data,
    input  logic      mem_cp0_reg_we,
    input  reg_addr_t mem_cp0_reg_write_addr,
    input  word_t     mem_cp0_reg_data,

    output logic      wb_valid,
    output oper_t     wb_oper,
    output logic      wb_write,
    output reg_addr_t wb_addr,
    output word_t     wb_data,
    output logic      whilo,
    output word_t     hi,
    output word_t     lo,
    output logic      cp0_we,
    output reg_addr_t cp0_addr,
    output word_t     cp0_data
);

    word_t              dmem [DMEM_WORDS];
    logic [DMEM_AW-1:0] dmem_idx;
    logic               advance;

    // word index from the byte address
    assign dmem_idx = mem_mem_oper_addr[DMEM_AW+1:2];
    assign advance  = !stall[ST_MEM];

    always_ff @(posedge clk) begin
        if (advance && mem_oper == OP_SW) begin
            dmem[dmem_idx] <= mem_mem_oper_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            wb_oper  <= OP_NOP;
            wb_write <= 1'b0;
            whilo    <= 1'b0;
            cp0_we   <= 1'b0;
        end else if (advance) begin
            wb_valid <= (mem_oper != OP_NOP);
            wb_oper  <= mem_oper;
            wb_write <= mem_wreg_write;
            whilo    <= mem_whilo;
            cp0_we   <= mem_cp0_reg_we;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            wb_addr  <= mem_wreg_addr;
            wb_data  <= (mem_oper == OP_LW) ? dmem[dmem_idx] : mem_wreg_data;
            hi       <= mem_hi;
            lo       <= mem_lo;
            cp0_addr <= mem_cp0_reg_write_addr;
            cp0_data <= mem_cp0_reg_data;
        end
    end

endmodule

`default_nettype wire

//--- mult_unit.sv
`default_nettype none

module mult_unit
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  start,
    input  logic  hold,
    input  word_t multiplicand,
    input  word_t multiplier,
    output logic  busy,
    output logic  done,
    output word_t hi,
    output word_t lo
);

    logic [2*WORD_W-1:0] acc;
    logic [2*WORD_W-1:0] mcand_sh;
    logic [2*WORD_W-1:0] sum;
    word_t               mplier;
    logic [MULT_CNT_W-1:0] cnt;
    logic                last_step;

    assign last_step = (cnt == MULT_CNT_W'(MULT_STEPS - 1));

    // partial product of the current digit, already aligned
    assign sum  = acc + mcand_sh * mplier[MULT_DIGIT_W-1:0];
    assign done = busy && last_step;
    assign hi   = sum[2*WORD_W-1:WORD_W];
    assign lo   = sum[WORD_W-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (start) begin
            busy <= 1'b1;
            cnt  <= '0;
        end else if (busy && !hold) begin
            cnt <= cnt + 1'b1;
            if (last_step) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            acc      <= '0;
            mcand_sh <= {{WORD_W{1'b0}}, multiplicand};
            mplier   <= multiplier;
        end else if (busy && !hold) begin
            acc      <= sum;
            mcand_sh <= mcand_sh << MULT_DIGIT_W;
            mplier   <= mplier >> MULT_DIGIT_W;
        end
    end

endmodule

`default_nettype wire

//--- pipe_ctrl.sv
`default_nettype none

module pipe_ctrl
    import pipe_pkg::*;
(
    input  logic   mult_busy,
    input  logic   wb_valid,
    input  logic   wb_ready,
    output stall_t stall,
    output logic   in_ready
);

    logic wb_blocked;

    // retired result not taken, freeze everything
    assign wb_blocked = wb_valid && !wb_ready;

    always_comb begin
        stall[ST_WB]  = wb_blocked;
        stall[ST_MEM] = wb_blocked;
        // execute keeps flowing during a multiply so the product
        // can reach ex_mem on the last step, idle cycles carry OP_NOP
        stall[ST_EX]  = wb_blocked;
        stall[ST_ID]  = wb_blocked || mult_busy;
        stall[ST_IF]  = stall[ST_ID];
        stall[ST_PC]  = stall[ST_ID];
    end

    assign in_ready = !stall[ST_ID];

endmodule

`default_nettype wire

//--- pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    // one stall bit per stage, pc at bit 0
    typedef logic [5:0] stall_t;

    localparam int ST_PC  = 0;
    localparam int ST_IF  = 1;
    localparam int ST_ID  = 2;
    localparam int ST_EX  = 3;
    localparam int ST_MEM = 4;
    localparam int ST_WB  = 5;

    // multiplier works one 8-bit digit of the multiplier per step
    localparam int MULT_STEPS   = 4;
    localparam int MULT_DIGIT_W = 8;
    localparam int MULT_CNT_W   = $clog2(MULT_STEPS);

endpackage

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_exec_mem_slice -f src.f

./obj_dir/Vtb_exec_mem_slice 2>&1 | tee sim.log

if grep -qx "sim passed" sim.log; then
    echo "result: pass"
else
    echo "result: pass message not found in sim.log"
    exit 1
fi

//--- src.f
isa_pkg.sv
pipe_pkg.sv
alu_unit.sv
mult_unit.sv
ex_stage.sv
pipe_ctrl.sv
ex_mem.sv
mem_stage.sv
exec_mem_slice.sv
exec_mem_slice_assert.sv
tb_exec_mem_slice.sv

//--- tb_exec_mem_slice.sv
`default_nettype none

module tb_exec_mem_slice
    import isa_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_OPS        = 200;
    localparam int TIMEOUT_CYCLES = NUM_OPS * 16;

    // one expected writeback
    typedef struct packed {
        oper_t     oper;
        logic      wr;
        reg_addr_t addr;
        word_t     data;
        logic      whilo;
        word_t     hi;
        word_t     lo;
        logic      cp0_we;
        reg_addr_t cp0_addr;
        word_t     cp0_data;
    } exp_t;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      in_valid;
    logic      in_ready;
    oper_t     in_oper;
    word_t     in_src_a;
    word_t     in_src_b;
    word_t     in_offset;
    reg_addr_t in_dest;
    logic      wb_valid;
    logic      wb_ready;
    oper_t     wb_oper;
    logic      wb_write;
    reg_addr_t wb_addr;
    word_t     wb_data;
    logic      whilo;
    word_t     hi;
    word_t     lo;
    logic      cp0_we;
    reg_addr_t cp0_addr;
    word_t     cp0_data;

    integer    seed = 32'h6ea85131;
    word_t     ram_model [DMEM_WORDS];
    int        written_idx [$];
    exp_t      exp_q [$];
    int        check_errors = 0;
    int        extra_errors = 0;
    int        retired = 0;
    int        pushed = 0;
    int        issued = 0;
    int        cycles = 0;
    logic      accepted;

    exec_mem_slice i_exec_mem_slice (.*);

    always #50 clk = ~clk;

    function automatic int unsigned rand_below(int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // expected writeback bundle from the instruction rules
    function automatic exp_t expected_result(oper_t op, word_t a, word_t b, word_t off,
                                             reg_addr_t dest);
        exp_t        e;
        word_t       addr;
        logic [63:0] prod;
        e    = '0;
        addr = a + off;
        prod = {32'b0, a} * {32'b0, b};
        case (op)
            OP_ADD:  e.data = a + b;
            OP_SUB:  e.data = a - b;
            OP_AND:  e.data = a & b;
            OP_OR:   e.data = a | b;
            OP_XOR:  e.data = a ^ b;
            OP_SLT:  e.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_LW:   e.data = ram_model[addr[DMEM_AW+1:2]];
            default: e.data = ZERO_WORD;
        endcase
        e.oper     = op;
        e.wr       = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_LW};
        e.addr     = dest;
        e.whilo    = (op == OP_MULTU);
        e.hi       = prod[63:32];
        e.lo       = prod[31:0];
        e.cp0_we   = (op == OP_MTC0);
        e.cp0_addr = dest;
        e.cp0_data = b;
        return e;
    endfunction

    task automatic report_mismatch(string msg);
        $display("CHECK FAILED @ %0t ns: %s", $time, msg);
        check_errors++;
    endtask

    task automatic check_flag(string what, logic got, logic exp);
        if (got !== exp) begin
            report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
        end
    endtask

    task automatic check_oper(string what, oper_t got, oper_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf("%s is %s, expected %s", what, got.name(), exp.name()));
        end
    endtask

    task automatic check_wreg(logic we, reg_addr_t addr, word_t data, exp_t e);
        check_flag("wb_write", we, e.wr);
        if (e.wr && (addr !== e.addr || data !== e.data)) begin
            report_mismatch($sformatf("%s wrote r%0d = %h, expected r%0d = %h",
                e.oper.name(), addr, data, e.addr, e.data));
        end
    endtask

    task automatic check_hilo(logic we, word_t got_hi, word_t got_lo, exp_t e);
        check_flag("whilo", we, e.whilo);
        if (e.whilo && (got_hi !== e.hi || got_lo !== e.lo)) begin
            report_mismatch($sformatf("MULTU gave hi:lo %h:%h, expected %h:%h",
                got_hi, got_lo, e.hi, e.lo));
        end
    endtask

    task automatic check_cp0(logic we, reg_addr_t addr, word_t data, exp_t e);
        check_flag("cp0_we", we, e.cp0_we);
        if (e.cp0_we && (addr !== e.cp0_addr || data !== e.cp0_data)) begin
            report_mismatch($sformatf("MTC0 wrote cp0 %0d = %h, expected cp0 %0d = %h",
                addr, data, e.cp0_addr, e.cp0_data));
        end
    endtask

    // outputs that must stay quiet before the first operation
    task automatic check_idle();
        check_flag("wb_valid", wb_valid, 1'b0);
        check_flag("wb_write", wb_write, 1'b0);
        check_flag("whilo", whilo, 1'b0);
        check_flag("cp0_we", cp0_we, 1'b0);
        check_flag("in_ready", in_ready, 1'b1);
        check_flag("mult_busy", i_exec_mem_slice.mult_busy, 1'b0);
        check_oper("ex_mem oper", i_exec_mem_slice.mem_oper, OP_NOP);
    endtask

    task automatic drive_new_op();
        oper_t       op;
        word_t       addr;
        int unsigned idx;
        op = oper_t'(rand_below(11));
        // loads only from words that a store has written
        if (op == OP_LW && written_idx.size() == 0) begin
            op = OP_SW;
        end
        in_valid  = 1'b1;
        in_oper   = op;
        in_src_a  = $random(seed);
        in_src_b  = $random(seed);
        in_offset = $random(seed);
        in_dest   = reg_addr_t'(rand_below(31) + 1);
        if (op == OP_LW || op == OP_SW) begin
            if (op == OP_LW) begin
                idx = written_idx[rand_below(written_idx.size())];
            end else begin
                idx = rand_below(DMEM_WORDS);
            end
            addr              = $random(seed);
            addr[DMEM_AW+1:2] = idx[DMEM_AW-1:0];
            addr[1:0]         = 2'b00;
            in_offset         = addr - in_src_a;
        end
    endtask

    task automatic record_issue();
        exp_t  e;
        word_t addr;
        e    = expected_result(in_oper, in_src_a, in_src_b, in_offset, in_dest);
        addr = in_src_a + in_offset;
        issued++;
        if (in_oper == OP_SW) begin
            ram_model[addr[DMEM_AW+1:2]] = in_src_b;
            written_idx.push_back(int'(addr[DMEM_AW+1:2]));
        end
        if (in_oper != OP_NOP) begin
            exp_q.push_back(e);
            pushed++;
        end
    endtask

    task automatic print_error_counts();
        $display("errors: %0d mismatches, %0d unexpected, %0d missing, %0d of %0d retired",
            check_errors, extra_errors, exp_q.size(), retired, pushed);
    endtask

    initial begin
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_oper   = OP_NOP;
        in_src_a  = ZERO_WORD;
        in_src_b  = ZERO_WORD;
        in_offset = ZERO_WORD;
        in_dest   = REG_ZERO;
        wb_ready  = 1'b1;
        accepted  = 1'b0;

        repeat (3) @(posedge clk);
        @(negedge clk);
        check_idle();
        @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_idle();

        while (issued < NUM_OPS) begin
            @(posedge clk);
            #1;
            wb_ready = (rand_below(10) >= 3);
            if (!in_valid || accepted) begin
                if (rand_below(8) == 0) begin
                    in_valid = 1'b0;
                end else begin
                    drive_new_op();
                end
            end
            // handshake is settled half a cycle before the edge
            @(negedge clk);
            accepted = in_valid && in_ready;
            if (accepted) begin
                record_issue();
            end
        end

        @(posedge clk);
        #1;
        in_valid = 1'b0;
        while (exp_q.size() != 0) begin
            wb_ready = (rand_below(10) >= 3);
            @(posedge clk);
            #1;
        end
        wb_ready = 1'b1;
        // extra cycles catch duplicated results
        repeat (8) @(posedge clk);

        print_error_counts();
        if (check_errors == 0 && extra_errors == 0 && exp_q.size() == 0 && retired == pushed) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // retirement happens at the next rising edge
    always @(negedge clk) begin : compare
        exp_t e;
        if (rst_n && wb_valid && wb_ready) begin
            if (exp_q.size() == 0) begin
                $display("%0t ns: a %s result retired with no operation outstanding",
                    $time, wb_oper.name());
                extra_errors++;
            end else begin
                e = exp_q.pop_front();
                check_oper("wb_oper", wb_oper, e.oper);
                check_wreg(wb_write, wb_addr, wb_data, e);
                check_hilo(whilo, hi, lo, e);
                check_cp0(cp0_we, cp0_addr, cp0_data, e);
                retired++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            print_error_counts();
            $display("sim failed");
            $finish;
        end
    end

endmodule

`default_nettype wire
